//--- tb.f
src/sprite_pkg.sv
src/bram.sv
src/sprite_attr_table.sv
src/sprite_render_ctrl.sv
src/sprite_fetch.sv
src/sprite_blitter.sv
src/scanline_buffer.sv
src/sprite_engine.sv
tb/tb_mem_model.sv
tb/tb_sprite_engine.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --timing -Wno-fatal
TOP       = tb_sprite_engine
FILELIST  = tb.f
OBJ_DIR   = obj_dir

SOURCES = $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_sprite_engine.sv
// Sprite engine testbench
`timescale 1ns/1ns

module tb_sprite_engine;

	localparam int SPRITES     = 16;
	localparam int LINE_PIXELS = 64;
	localparam int NTESTS      = 7;
	localparam int TIMEOUT     = 5000;

	// One sprite of a test case
	typedef struct packed {
		logic [3:0]  test;
		logic [3:0]  index;
		logic [9:0]  x;
		logic        enable;
		logic [3:0]  palette;
		logic        stride;
		logic [9:0]  y_start;
		logic [9:0]  y_end;
		logic [5:0]  width_m1;
		logic [15:0] base;
	} sprite_row_t;

	typedef struct packed {
		logic [9:0] display_y;
		logic       abort;
		logic       all_hit;
	} test_row_t;

	logic                          CLK;
	logic                          RSTb;
	sprite_pkg::reg_write_t        reg_wr;
	logic                          h_tick;
	logic [sprite_pkg::X_BITS-1:0] display_y;
	logic [sprite_pkg::X_BITS-1:0] display_x;
	logic                          display_en;
	sprite_pkg::mem_rsp_t          mem_rsp;
	logic [7:0]                    color_index;
	logic                          busy;
	sprite_pkg::mem_req_t          mem_req;
	int                            violations;

	test_row_t   tests [NTESTS];
	string       names [NTESTS];
	sprite_row_t sprites [$];
	sprite_row_t line_set [SPRITES];
	logic [7:0]  expected [LINE_PIXELS];
	logic [7:0]  got [LINE_PIXELS];
	int          errors;
	int          test_errors;
	int          failed;
	int          tests_run;
	int          viol_start;

	sprite_engine #(
		.SPRITE_BITS (4),
		.LINE_PIXELS (LINE_PIXELS),
		.MEM_CREDITS (2)
	) uut (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.reg_wr      (reg_wr),
		.h_tick      (h_tick),
		.display_y   (display_y),
		.display_x   (display_x),
		.display_en  (display_en),
		.mem_rsp     (mem_rsp),
		.color_index (color_index),
		.busy        (busy),
		.mem_req     (mem_req)
	);

	tb_mem_model #(.MEM_CREDITS(2)) mem (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp),
		.violations (violations)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic add_sprite(input int t, input int idx, input int x, input int en,
		input int pal, input int st, input int ys, input int ye, input int wm1,
		input int base);
		sprite_row_t s;
		s.test     = 4'(t);
		s.index    = 4'(idx);
		s.x        = 10'(x);
		s.enable   = 1'(en);
		s.palette  = 4'(pal);
		s.stride   = 1'(st);
		s.y_start  = 10'(ys);
		s.y_end    = 10'(ye);
		s.width_m1 = 6'(wm1);
		s.base     = 16'(base);
		sprites.push_back(s);
	endtask

	task automatic fill_tables();
		names[0] = "single sprite stride 32";
		tests[0] = '{display_y: 10'd12, abort: 1'b0, all_hit: 1'b0};
		add_sprite(0, 3, 5, 1, 2, 0, 10, 20, 13, 'h010A);
		names[1] = "single sprite stride 64";
		tests[1] = '{display_y: 10'd33, abort: 1'b0, all_hit: 1'b0};
		add_sprite(1, 7, 20, 1, 9, 1, 0, 40, 31, 'h2000);
		names[2] = "off-line and disabled sprites";
		tests[2] = '{display_y: 10'd30, abort: 1'b0, all_hit: 1'b0};
		add_sprite(2, 0, 4, 1, 1, 0, 50, 60, 15, 'h0040);
		add_sprite(2, 1, 8, 0, 5, 0, 0, 99, 15, 'h0080);
		add_sprite(2, 2, 12, 1, 3, 1, 31, 40, 15, 'h00C0);
		add_sprite(2, 3, 16, 1, 7, 0, 20, 29, 15, 'h0100);
		names[3] = "overlap priority";
		tests[3] = '{display_y: 10'd7, abort: 1'b0, all_hit: 1'b0};
		add_sprite(3, 2, 10, 1, 1, 0, 0, 99, 23, 'h0300);
		add_sprite(3, 5, 0, 1, 6, 0, 0, 99, 19, 'h1111);
		add_sprite(3, 9, 18, 1, 12, 1, 0, 99, 15, 'h0455);
		names[4] = "clipping and clear on read";
		tests[4] = '{display_y: 10'd5, abort: 1'b0, all_hit: 1'b0};
		add_sprite(4, 4, 50, 1, 3, 0, 2, 9, 31, 'h0777);
		add_sprite(4, 12, 63, 1, 14, 1, 5, 5, 3, 'h0999);
		names[5] = "abort mid-render";
		tests[5] = '{display_y: 10'd44, abort: 1'b1, all_hit: 1'b1};
		names[6] = "all sprites, random latency";
		tests[6] = '{display_y: 10'd100, abort: 1'b0, all_hit: 1'b1};
	endtask

	// Sprite set where every sprite covers the line
	function automatic sprite_row_t sweep_sprite(input int i);
		sprite_row_t s;
		s.test     = 4'd0;
		s.index    = 4'(i);
		s.x        = 10'(i * 3 + 2);
		s.enable   = 1'b1;
		s.palette  = 4'(i);
		s.stride   = 1'(i);
		s.y_start  = 10'd0;
		s.y_end    = 10'd500;
		s.width_m1 = 6'(10 + i);
		s.base     = 16'(i * 'h0105 + 'h0033);
		return s;
	endfunction

	function automatic void select_sprites(input int t);
		for (int s = 0; s < SPRITES; s++) begin
			line_set[s] = tests[t].all_hit ? sweep_sprite(s) : '0;
		end
		foreach (sprites[k]) begin
			if (int'(sprites[k].test) == t) begin
				line_set[sprites[k].index] = sprites[k];
			end
		end
	endfunction

	// Sheet contents as the memory serves them
	function automatic logic [15:0] sheet_word(input logic [15:0] addr);
		return addr ^ 16'h5A3C;
	endfunction

	// Expected line: index order, nibble 0 transparent, clip at the line end
	function automatic void reference_line(input logic [9:0] y);
		logic [15:0] row;
		logic [15:0] addr;
		logic [15:0] data;
		logic [3:0]  nib;
		int          px;
		for (int p = 0; p < LINE_PIXELS; p++) begin
			expected[p] = 8'h00;
		end
		for (int s = 0; s < SPRITES; s++) begin
			if (line_set[s].enable && (y >= line_set[s].y_start) && (y <= line_set[s].y_end)) begin
				row = 16'(y - line_set[s].y_start);
				for (int i = 0; i <= int'(line_set[s].width_m1); i++) begin
					addr = line_set[s].base + row * (line_set[s].stride ? 16'd64 : 16'd32)
						+ 16'(i / 4);
					data = sheet_word(addr);
					nib  = data[4 * (i % 4) +: 4];
					px   = int'(line_set[s].x) + i;
					if ((nib != 4'h0) && (px < LINE_PIXELS)) begin
						expected[px] = {line_set[s].palette, nib};
					end
				end
			end
		end
	endfunction

	task automatic write_reg(input sprite_pkg::table_sel_t sel, input int index,
		input logic [15:0] data);
		sprite_pkg::reg_write_t w;
		w.wr    = 1'b1;
		w.sel   = sel;
		w.index = 8'(index);
		w.data  = data;
		@(posedge CLK);
		reg_wr <= w;
	endtask

	task automatic load_sprite(input int index, input sprite_row_t s);
		write_reg(sprite_pkg::TBL_X, index, {s.stride, s.palette, s.enable, s.x});
		write_reg(sprite_pkg::TBL_Y, index, {s.width_m1, s.y_start});
		write_reg(sprite_pkg::TBL_H, index, {6'd0, s.y_end});
		write_reg(sprite_pkg::TBL_A, index, s.base);
	endtask

	task automatic pulse_tick();
		@(posedge CLK);
		h_tick <= 1'b1;
		@(posedge CLK);
		h_tick <= 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge CLK);
		while (busy && (n < TIMEOUT)) begin
			@(negedge CLK);
			n++;
		end
		if (busy) begin
			$display("timeout at %0t: busy still high after %0d cycles", $time, TIMEOUT);
			test_errors++;
		end
	endtask

	task automatic wait_request();
		int n;
		n = 0;
		@(negedge CLK);
		while (!mem_req.valid && (n < TIMEOUT)) begin
			@(negedge CLK);
			n++;
		end
		if (!mem_req.valid) begin
			$display("timeout at %0t: render never issued a memory read", $time);
			test_errors++;
		end
	endtask

	// Color arrives one cycle after its address
	task automatic read_line();
		for (int i = 0; i <= LINE_PIXELS; i++) begin
			@(posedge CLK);
			if (i < LINE_PIXELS) begin
				display_x  <= 10'(i);
				display_en <= 1'b1;
			end else begin
				display_en <= 1'b0;
			end
			if (i > 0) begin
				@(negedge CLK);
				got[i - 1] = color_index;
			end
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
			test_errors++;
		end
	endtask

	task automatic compare_line(input logic zeros);
		for (int i = 0; i < LINE_PIXELS; i++) begin
			check_value($sformatf("color_index[%0d]", i), zeros ? 16'h0 : 16'(expected[i]),
				16'(got[i]));
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			$display("test %0d %s: FAIL with %0d errors", tests_run, name, test_errors);
			failed++;
		end
		errors += test_errors;
	endtask

	initial begin
		errors     = 0;
		failed     = 0;
		tests_run  = 0;
		RSTb       <= 1'b0;
		reg_wr     <= '0;
		h_tick     <= 1'b0;
		display_y  <= '0;
		display_x  <= '0;
		display_en <= 1'b0;
		fill_tables();
		repeat (3) @(posedge CLK);
		RSTb <= 1'b1;
		@(negedge CLK);
		test_errors = 0;
		check_value("busy", 16'h0, 16'(busy));
		check_value("mem_req.valid", 16'h0, 16'(mem_req.valid));
		finish_test("reset state");

		for (int t = 0; t < NTESTS; t++) begin
			test_errors = 0;
			viol_start  = violations;
			select_sprites(t);
			reference_line(tests[t].display_y);
			for (int s = 0; s < SPRITES; s++) begin
				load_sprite(s, line_set[s]);
			end
			@(posedge CLK);
			reg_wr.wr <= 1'b0;
			display_y <= tests[t].display_y;
			pulse_tick();
			if (tests[t].abort) begin
				// Restart the line while reads are outstanding
				wait_request();
				repeat (3) @(posedge CLK);
				pulse_tick();
			end
			wait_idle();
			pulse_tick();
			read_line();
			compare_line(1'b0);
			read_line();
			compare_line(1'b1);

			// Empty render, then drain the other buffer
			for (int s = 0; s < SPRITES; s++) begin
				write_reg(sprite_pkg::TBL_X, s, 16'h0000);
			end
			@(posedge CLK);
			reg_wr.wr <= 1'b0;
			wait_idle();
			pulse_tick();
			read_line();
			wait_idle();
			if (violations != viol_start) begin
				$display("memory model saw %0d reads issued without credit",
					violations - viol_start);
				test_errors++;
			end
			finish_test(names[t]);
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- tb/tb_mem_model.sv
// Sheet memory model with random latency
`timescale 1ns/1ns

module tb_mem_model #(
	parameter int MEM_CREDITS = 2
) (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  sprite_pkg::mem_req_t mem_req,
	output sprite_pkg::mem_rsp_t mem_rsp,
	output int                   violations
);

	sprite_pkg::mem_rsp_t rsp = '0;
	int                   credits = MEM_CREDITS;
	int                   bad = 0;
	int                   cycle = 0;
	int                   last_due = 0;
	logic [31:0]          lcg = 32'h83dc74c9;
	logic [15:0]          addr_q [$];
	int                   due_q [$];

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	assign mem_rsp    = rsp;
	assign violations = bad;

	always @(posedge CLK) begin : step
		int due;
		cycle = cycle + 1;
		if (!RSTb) begin
			credits  = MEM_CREDITS;
			last_due = 0;
			addr_q.delete();
			due_q.delete();
			rsp <= '0;
		end else begin
			// Requests first, so a credit comes back only after its response left
			if (mem_req.valid) begin
				if (credits == 0) begin
					bad = bad + 1;
					$display("credit error at %0t: read of %h issued with no credit left",
						$time, mem_req.addr);
				end
				credits = credits - 1;
				lcg     = lcg_next(lcg);
				due     = cycle + 1 + int'(lcg[31:16] % 16'd6);
				// Keep responses in order
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				addr_q.push_back(mem_req.addr);
				due_q.push_back(due);
			end
			if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
				rsp.valid <= 1'b1;
				rsp.data  <= addr_q[0] ^ 16'h5A3C;
				void'(addr_q.pop_front());
				void'(due_q.pop_front());
				credits = credits + 1;
			end else begin
				rsp <= '0;
			end
		end
	end

endmodule

//--- src/sprite_engine.sv
// Sprite engine top level
`timescale 1ns/1ns

module sprite_engine #(
	parameter int SPRITE_BITS = 8,
	parameter int LINE_PIXELS = 800,
	parameter int MEM_CREDITS = 2
) (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  sprite_pkg::reg_write_t        reg_wr,
	input  logic                          h_tick,
	input  logic [sprite_pkg::X_BITS-1:0] display_y,
	input  logic [sprite_pkg::X_BITS-1:0] display_x,
	input  logic                          display_en,
	input  sprite_pkg::mem_rsp_t          mem_rsp,
	output logic [7:0]                    color_index,
	output logic                          busy,
	output sprite_pkg::mem_req_t          mem_req
);

	sprite_pkg::sprite_attr_t          attr;
	logic [SPRITE_BITS-1:0]            rd_index;
	logic                              fetch_start;
	logic [15:0]                       fetch_addr;
	logic [sprite_pkg::WORDS_BITS-1:0] fetch_words;
	logic                              flush;
	sprite_pkg::blit_job_t             blit_job;
	logic                              swap;
	logic                              blit_done;
	logic [15:0]                       word;
	logic                              word_valid;
	logic                              word_take;
	sprite_pkg::pixel_write_t          pix_wr;

	sprite_attr_table #(.SPRITE_BITS(SPRITE_BITS)) u_attr (
		.CLK      (CLK),
		.reg_wr   (reg_wr),
		.rd_index (rd_index),
		.attr     (attr)
	);

	sprite_render_ctrl #(.SPRITE_BITS(SPRITE_BITS)) u_ctrl (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.h_tick      (h_tick),
		.display_y   (display_y),
		.attr        (attr),
		.blit_done   (blit_done),
		.rd_index    (rd_index),
		.fetch_start (fetch_start),
		.fetch_addr  (fetch_addr),
		.fetch_words (fetch_words),
		.flush       (flush),
		.blit_job    (blit_job),
		.swap        (swap),
		.busy        (busy)
	);

	sprite_fetch #(.MEM_CREDITS(MEM_CREDITS)) u_fetch (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.fetch_start (fetch_start),
		.fetch_addr  (fetch_addr),
		.fetch_words (fetch_words),
		.flush       (flush),
		.mem_rsp     (mem_rsp),
		.word_take   (word_take),
		.mem_req     (mem_req),
		.word        (word),
		.word_valid  (word_valid)
	);

	sprite_blitter #(.LINE_PIXELS(LINE_PIXELS)) u_blit (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.blit_job   (blit_job),
		.flush      (flush),
		.word       (word),
		.word_valid (word_valid),
		.word_take  (word_take),
		.pix_wr     (pix_wr),
		.blit_done  (blit_done)
	);

	scanline_buffer #(.LINE_PIXELS(LINE_PIXELS)) u_line (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.swap        (swap),
		.pix_wr      (pix_wr),
		.display_x   (display_x),
		.display_en  (display_en),
		.color_index (color_index)
	);

endmodule

//--- src/scanline_buffer.sv
// Double-buffered scanline RAMs
`timescale 1ns/1ns

module scanline_buffer #(
	parameter int LINE_PIXELS = 800
) (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic                          swap,
	input  sprite_pkg::pixel_write_t      pix_wr,
	input  logic [sprite_pkg::X_BITS-1:0] display_x,
	input  logic                          display_en,
	output logic [7:0]                    color_index
);

	localparam int AW = $clog2(LINE_PIXELS);

	logic          front;
	logic          rd_sel;
	logic          rd_ok;
	logic [AW-1:0] clr_addr;
	logic [7:0]    rd_data [2];
	logic [AW-1:0] wr_addr [2];
	logic [7:0]    wr_data [2];
	logic          wr_en [2];

	for (genvar b = 0; b < 2; b++) begin : g_line
		bram #(
			.DATA_BITS (8),
			.ADDR_BITS (AW)
		) u_ram (
			.CLK     (CLK),
			.rd_addr (display_x[AW-1:0]),
			.rd_data (rd_data[b]),
			.wr_addr (wr_addr[b]),
			.wr_data (wr_data[b]),
			.wr_en   (wr_en[b])
		);
	end

	always_comb begin
		for (int b = 0; b < 2; b++) begin
			if (rd_ok && (rd_sel == 1'(b))) begin
				// Display side clears what it read last cycle
				wr_en[b]   = 1'b1;
				wr_addr[b] = clr_addr;
				wr_data[b] = 8'd0;
			end else begin
				wr_en[b]   = pix_wr.en && (front != 1'(b));
				wr_addr[b] = pix_wr.x[AW-1:0];
				wr_data[b] = pix_wr.color;
			end
		end
	end

	assign color_index = rd_ok ? rd_data[rd_sel] : 8'd0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			front <= 1'b0;
			rd_ok <= 1'b0;
		end else begin
			if (swap) begin
				front <= !front;
			end
			rd_ok <= display_en && (display_x < LINE_PIXELS);
		end
	end

	// Remember which buffer and address were read
	always_ff @(posedge CLK) begin
		rd_sel   <= front;
		clr_addr <= display_x[AW-1:0];
	end

endmodule

//--- src/sprite_blitter.sv
// Sprite pixel blitter
`timescale 1ns/1ns

module sprite_blitter #(
	parameter int LINE_PIXELS = 800
) (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  sprite_pkg::blit_job_t    blit_job,
	input  logic                     flush,
	input  logic [15:0]              word,
	input  logic                     word_valid,
	output logic                     word_take,
	output sprite_pkg::pixel_write_t pix_wr,
	output logic                     blit_done
);

	logic                        active;
	// Spare top bit keeps x + i from wrapping back onto the line
	logic [sprite_pkg::X_BITS:0] x_pos;
	logic [5:0]                  left;
	logic [1:0]                  nib;
	logic [3:0]                  palette;
	logic [3:0]                  pixel;
	logic                        fire;
	logic                        last;

	assign fire  = active && word_valid && !flush;
	assign last  = (left == '0);
	assign pixel = word[{nib, 2'b00} +: 4];

	// Word done after its fourth nibble or the sprite's last pixel
	assign word_take = fire && ((nib == 2'd3) || last);

	// Nibble zero is transparent
	assign pix_wr.en    = fire && (pixel != 4'd0) && (x_pos < LINE_PIXELS);
	assign pix_wr.x     = x_pos[sprite_pkg::X_BITS-1:0];
	assign pix_wr.color = {palette, pixel};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			active    <= 1'b0;
			blit_done <= 1'b0;
		end else begin
			blit_done <= fire && last;
			if (flush) begin
				active <= 1'b0;
			end else if (blit_job.valid) begin
				active <= 1'b1;
			end else if (fire && last) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (blit_job.valid) begin
			x_pos   <= {1'b0, blit_job.x};
			left    <= blit_job.width_m1;
			nib     <= 2'd0;
			palette <= blit_job.palette;
		end else if (fire) begin
			x_pos <= x_pos + 1'b1;
			left  <= left - 1'b1;
			nib   <= nib + 1'b1;
		end
	end

endmodule

//--- src/sprite_fetch.sv
// Sprite row fetch with read credits
`timescale 1ns/1ns

module sprite_fetch #(
	parameter int MEM_CREDITS = 2
) (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              fetch_start,
	input  logic [15:0]                       fetch_addr,
	input  logic [sprite_pkg::WORDS_BITS-1:0] fetch_words,
	input  logic                              flush,
	input  sprite_pkg::mem_rsp_t              mem_rsp,
	input  logic                              word_take,
	output sprite_pkg::mem_req_t              mem_req,
	output logic [15:0]                       word,
	output logic                              word_valid
);

	localparam int CW = $clog2(MEM_CREDITS + 1);
	localparam int PW = (MEM_CREDITS > 1) ? $clog2(MEM_CREDITS) : 1;

	logic [CW-1:0]                     credits;
	logic [CW-1:0]                     count;
	logic [CW-1:0]                     discard;
	logic [CW-1:0]                     in_flight;
	logic [sprite_pkg::WORDS_BITS-1:0] remaining;
	logic [15:0]                       addr;
	logic [15:0]                       fifo [MEM_CREDITS];
	logic [PW-1:0]                     wr_ptr;
	logic [PW-1:0]                     rd_ptr;
	logic                              issue;
	logic                              drop;
	logic                              push;
	logic                              pop;

	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		return (p == PW'(MEM_CREDITS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign issue         = (remaining != '0) && (credits != '0);
	assign mem_req.valid = issue;
	assign mem_req.addr  = addr;

	// Responses owed to an aborted job are dropped
	assign drop = mem_rsp.valid && ((discard != '0) || flush);
	assign push = mem_rsp.valid && !drop;
	assign pop  = word_take && word_valid;

	// Each credit is either free, in flight or held by a FIFO entry
	assign in_flight  = CW'(MEM_CREDITS) - credits - count;
	assign word       = fifo[rd_ptr];
	assign word_valid = (count != '0);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			credits   <= CW'(MEM_CREDITS);
			count     <= '0;
			discard   <= '0;
			remaining <= '0;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
		end else if (flush) begin
			// FIFO entries give their credits back now, reads in flight on arrival
			credits   <= credits - CW'(issue) + count + CW'(mem_rsp.valid);
			discard   <= in_flight + CW'(issue) - CW'(mem_rsp.valid);
			count     <= '0;
			remaining <= '0;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
		end else begin
			credits <= credits - CW'(issue) + CW'(pop) + CW'(drop);
			count   <= count + CW'(push) - CW'(pop);
			if (drop) begin
				discard <= discard - 1'b1;
			end
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			if (fetch_start) begin
				remaining <= fetch_words;
			end else if (issue) begin
				remaining <= remaining - 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch_start) begin
			addr <= fetch_addr;
		end else if (issue) begin
			addr <= addr + 1'b1;
		end
		if (push) begin
			fifo[wr_ptr] <= mem_rsp.data;
		end
	end

endmodule

//--- src/sprite_render_ctrl.sv
// Sprite render sequencer
`timescale 1ns/1ns

module sprite_render_ctrl #(
	parameter int SPRITE_BITS = 8
) (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              h_tick,
	input  logic [sprite_pkg::X_BITS-1:0]     display_y,
	input  sprite_pkg::sprite_attr_t          attr,
	input  logic                              blit_done,
	output logic [SPRITE_BITS-1:0]            rd_index,
	output logic                              fetch_start,
	output logic [15:0]                       fetch_addr,
	output logic [sprite_pkg::WORDS_BITS-1:0] fetch_words,
	output logic                              flush,
	output sprite_pkg::blit_job_t             blit_job,
	output logic                              swap,
	output logic                              busy
);

	sprite_pkg::render_state_t     state;
	logic [SPRITE_BITS-1:0]        index;
	logic [sprite_pkg::X_BITS-1:0] row;
	logic [15:0]                   row_offset;
	logic                          hit;
	logic                          job_valid;
	logic [sprite_pkg::X_BITS-1:0] job_x;
	logic [3:0]                    job_palette;
	logic [5:0]                    job_width_m1;

	assign hit = attr.enable && (display_y >= attr.y_start) && (display_y <= attr.y_end);

	// Sheet rows are 32 or 64 words apart
	assign row_offset = attr.stride ? {row, 6'd0} : {1'b0, row, 5'd0};

	assign rd_index = index;
	assign swap     = h_tick;
	assign busy     = (state != sprite_pkg::R_IDLE);
	assign flush    = h_tick && busy;

	assign blit_job.x        = job_x;
	assign blit_job.palette  = job_palette;
	assign blit_job.width_m1 = job_width_m1;
	assign blit_job.valid    = job_valid;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state       <= sprite_pkg::R_IDLE;
			index       <= '0;
			fetch_start <= 1'b0;
			job_valid   <= 1'b0;
		end else begin
			fetch_start <= 1'b0;
			job_valid   <= 1'b0;
			if (h_tick) begin
				// New line, rescan from sprite zero
				state <= sprite_pkg::R_READ;
				index <= '0;
			end else begin
				case (state)
					sprite_pkg::R_IDLE: begin
						state <= sprite_pkg::R_IDLE;
					end
					// Attribute RAM read in flight
					sprite_pkg::R_READ: begin
						state <= sprite_pkg::R_TEST;
					end
					sprite_pkg::R_TEST: begin
						state <= hit ? sprite_pkg::R_ADDR : sprite_pkg::R_NEXT;
					end
					sprite_pkg::R_ADDR: begin
						fetch_start <= 1'b1;
						job_valid   <= 1'b1;
						state       <= sprite_pkg::R_DRAW;
					end
					sprite_pkg::R_DRAW: begin
						if (blit_done) begin
							state <= sprite_pkg::R_NEXT;
						end
					end
					sprite_pkg::R_NEXT: begin
						if (index == '1) begin
							state <= sprite_pkg::R_IDLE;
						end else begin
							index <= index + 1'b1;
							state <= sprite_pkg::R_READ;
						end
					end
					default: begin
						state <= sprite_pkg::R_IDLE;
					end
				endcase
			end
		end
	end

	// Row number, then row start address and job fields
	always_ff @(posedge CLK) begin
		if (state == sprite_pkg::R_TEST) begin
			row <= display_y - attr.y_start;
		end
		if (state == sprite_pkg::R_ADDR) begin
			fetch_addr   <= attr.base + row_offset;
			fetch_words  <= {1'b0, attr.width_m1[5:2]} + 1'b1;
			job_x        <= attr.x;
			job_palette  <= attr.palette;
			job_width_m1 <= attr.width_m1;
		end
	end

endmodule

//--- src/sprite_attr_table.sv
// Sprite attribute tables
`timescale 1ns/1ns

module sprite_attr_table #(
	parameter int SPRITE_BITS = 8
) (
	input  logic                     CLK,
	input  sprite_pkg::reg_write_t   reg_wr,
	input  logic [SPRITE_BITS-1:0]   rd_index,
	output sprite_pkg::sprite_attr_t attr
);

	logic [15:0] word [4];

	// One RAM per table, in X Y H A order
	for (genvar t = 0; t < 4; t++) begin : g_table
		logic wr_en;

		assign wr_en = reg_wr.wr && (reg_wr.sel == sprite_pkg::table_sel_t'(t));

		bram #(
			.DATA_BITS (16),
			.ADDR_BITS (SPRITE_BITS)
		) u_ram (
			.CLK     (CLK),
			.rd_addr (rd_index),
			.rd_data (word[t]),
			.wr_addr (reg_wr.index[SPRITE_BITS-1:0]),
			.wr_data (reg_wr.data),
			.wr_en   (wr_en)
		);
	end

	// X word: position, enable, palette, stride
	assign attr.x        = word[0][sprite_pkg::X_BITS-1:0];
	assign attr.enable   = word[0][10];
	assign attr.palette  = word[0][14:11];
	assign attr.stride   = word[0][15];

	// Y word: first line and width
	assign attr.y_start  = word[1][sprite_pkg::X_BITS-1:0];
	assign attr.width_m1 = word[1][15:10];

	// H word holds the last line, upper bits reserved
	assign attr.y_end    = word[2][sprite_pkg::X_BITS-1:0];

	// Sheet base word address
	assign attr.base     = word[3];

endmodule

//--- src/bram.sv
// Simple dual-port block RAM
`timescale 1ns/1ns

module bram #(
	parameter int DATA_BITS = 16,
	parameter int ADDR_BITS = 8
) (
	input  logic                 CLK,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output logic [DATA_BITS-1:0] rd_data,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [DATA_BITS-1:0] wr_data,
	input  logic                 wr_en
);

	logic [DATA_BITS-1:0] mem [1 << ADDR_BITS];

	// Zero image at configuration
	initial begin
		for (int i = 0; i < (1 << ADDR_BITS); i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

//--- src/sprite_pkg.sv
// Sprite engine shared types

package sprite_pkg;

	// Pixel x and line y width
	localparam int X_BITS = 10;
	// Row word count, up to 16 words of four pixels
	localparam int WORDS_BITS = 5;

	// Target table of a register write
	typedef enum logic [1:0] {
		TBL_X,
		TBL_Y,
		TBL_H,
		TBL_A
	} table_sel_t;

	typedef struct packed {
		logic        wr;
		table_sel_t  sel;
		logic [7:0]  index;
		logic [15:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [X_BITS-1:0] x;
		logic              enable;
		logic [3:0]        palette;
		logic              stride;   // 0 is 32 words, 1 is 64 words
		logic [X_BITS-1:0] y_start;
		logic [5:0]        width_m1;
		logic [X_BITS-1:0] y_end;
		logic [15:0]       base;
	} sprite_attr_t;

	typedef struct packed {
		logic [X_BITS-1:0] x;
		logic [3:0]        palette;
		logic [5:0]        width_m1;
		logic              valid;
	} blit_job_t;

	typedef struct packed {
		logic              en;
		logic [X_BITS-1:0] x;
		logic [7:0]        color;
	} pixel_write_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] data;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		R_IDLE,
		R_READ,
		R_TEST,
		R_ADDR,
		R_DRAW,
		R_NEXT
	} render_state_t;

endpackage
